// File: nocSwitch.f
nocPkg.sv
grantTimer.sv
switchArbiter.sv
flitCrossbar.sv
routerSwitch.sv
tbRouterSwitch.sv
+incdir+.

// File: runSim.sh
#!/bin/sh
# Build the router switch testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f nocSwitch.f \
  --top-module tbRouterSwitch \
  -o simRouterSwitch

./obj_dir/simRouterSwitch | tee sim.log

if grep -q "SIMULATION PASSED" sim.log
then
  echo "Run passed"
  exit 0
else
  echo "Run failed, see sim.log"
  exit 1
fi

// File: tbTasks.svh
`ifndef tbTasksSvh
`define tbTasksSvh

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Helpers

task automatic checkEq(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
  checks++;
  if (expected !== actual)
  begin
    errors++;
    $display("CHECK FAILED %s: expected %0h, actual %0h at %0t",
             name, expected, actual, $time);
  end
endtask

// Inputs change 1 ns after the edge
task automatic nextCycle();
  @(posedge clk);
  #1;
endtask

function automatic nocPkg::flitT makeFlit(input nocPkg::flitIdT id,
                                          input nocPkg::pktLenT len);
  nocPkg::flitT f;
  f.id      = id;
  f.len     = len;
  f.payload = nocPkg::payloadT'($urandom);
  return f;
endfunction

// Random body flits on every port
task automatic driveBodyFlits();
  for (int p = 0; p < nocPkg::NumPorts; p++)
    portFlits[p] = makeFlit(3'd2, nocPkg::pktLenT'($urandom));
endtask

task automatic goIdle();
  req       = '0;
  portFlits = '0;
  nextCycle();
  nextCycle();
  checkEq("go idle grant", 32'd0, 32'(grant));
  checkEq("go idle valid", 32'd0, 32'(outValid));
endtask

// Grant must equal expGrant for the given number of cycles
task automatic expectHold(input string name, input nocPkg::portVecT expGrant,
                          input int cycles);
  for (int i = 0; i < cycles; i++)
  begin
    nextCycle();
    checkEq(name, 32'(expGrant), 32'(grant));
  end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests

task automatic testResetState();
  checkEq("reset grant", 32'd0, 32'(grant));
  checkEq("reset valid", 32'd0, 32'(outValid));
  expectHold("reset hold", 5'b00000, 2);
endtask

task automatic testTimeoutHold();
  goIdle();
  portFlits[2] = makeFlit(nocPkg::HeaderId, 12'd3);
  req          = 5'b00100;
  expectHold("timeout hold", 5'b00100, 3 + 1);   // len plus one
  expectHold("timeout idle", 5'b00000, 1);
  expectHold("timeout regrant", 5'b00100, 1);
endtask

task automatic testIdlePriority();
  goIdle();
  portFlits[1] = makeFlit(nocPkg::HeaderId, 12'd2);
  portFlits[3] = makeFlit(nocPkg::HeaderId, 12'd2);
  portFlits[4] = makeFlit(nocPkg::HeaderId, 12'd2);
  req          = 5'b11010;
  expectHold("idle priority", 5'b00010, 3);
  expectHold("idle priority next", 5'b01000, 1);  // W comes after N
endtask

task automatic testRoundRobin();
  nocPkg::pktLenT lens [nocPkg::NumPorts];
  int             p;
  goIdle();
  for (p = 0; p < nocPkg::NumPorts; p++)
  begin
    lens[p]      = nocPkg::pktLenT'(p + 1 + 5 * ($urandom % 2));  // Distinct per port
    portFlits[p] = makeFlit(nocPkg::HeaderId, lens[p]);
  end
  req = '1;
  for (p = 0; p <= nocPkg::NumPorts; p++)  // Back to L at the end
    expectHold("round robin", nocPkg::portVecT'(1 << (p % nocPkg::NumPorts)),
               int'(lens[p % nocPkg::NumPorts]) + 1);
endtask

task automatic testEarlyRelease();
  goIdle();
  portFlits[4] = makeFlit(nocPkg::HeaderId, 12'd10);
  req          = 5'b10000;
  expectHold("early release grant", 5'b10000, 1);
  portFlits[1] = makeFlit(nocPkg::HeaderId, 12'd1);
  req          = 5'b10010;
  expectHold("early release grant", 5'b10000, 1);
  req = 5'b00010;                          // S lets go well before timeout
  expectHold("early release next", 5'b00010, 1);
  req = '0;
  expectHold("early release idle", 5'b00000, 1);
endtask

task automatic testDataPath();
  nocPkg::flitT prevFlit;
  goIdle();
  portFlits[3] = makeFlit(nocPkg::HeaderId, 12'd20);
  req          = 5'b01000;
  expectHold("data path grant", 5'b01000, 1);
  driveBodyFlits();
  for (int i = 0; i < 8; i++)
  begin
    prevFlit = portFlits[3];
    nextCycle();
    driveBodyFlits();                      // Inputs move on before the sample
    @(negedge clk);
    checkEq("data path flit", 32'(prevFlit), 32'(outFlit));
    checkEq("data path valid", 32'd1, 32'(outValid));
  end
  prevFlit = portFlits[3];
  nextCycle();
  req = '0;
  nextCycle();
  checkEq("data path drop valid", 32'd0, 32'(outValid));
  checkEq("data path drop grant", 32'd0, 32'(grant));
  driveBodyFlits();
  nextCycle();
  checkEq("data path hold flit", 32'(prevFlit), 32'(outFlit));  // Nothing granted
endtask

`endif

// File: tbRouterSwitch.sv
`timescale 1ns/10ps

module tbRouterSwitch;

  localparam int ClkPeriod  = 4;
  localparam int TestCycles = 500;         // Loose bound on the whole sequence
  localparam int WatchdogNs = 2 * TestCycles * ClkPeriod;

  logic                                clk;
  logic                                rst;
  nocPkg::portVecT                     req;
  nocPkg::flitT [nocPkg::NumPorts-1:0] portFlits;
  nocPkg::portVecT                     grant;
  nocPkg::flitT                        outFlit;
  logic                                outValid;

  int errors;
  int checks;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // DUT

  routerSwitch UUT
  (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .portFlits (portFlits),
    .grant     (grant),
    .outFlit   (outFlit),
    .outValid  (outValid)
  );

  `include "tbTasks.svh"

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clock and watchdog

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial
  begin
    #WatchdogNs;
    $display("Timeout: test sequence still running after %0d ns", WatchdogNs);
    $display("SIMULATION FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence

  initial
  begin
    errors    = 0;
    checks    = 0;
    void'($urandom(88));
    rst       = 1'b1;
    req       = '0;
    portFlits = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;                            // Released off the edge

    testResetState();
    testTimeoutHold();
    testIdlePriority();
    testRoundRobin();
    testEarlyRelease();
    testDataPath();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: routerSwitch.sv
`timescale 1ns/10ps

module routerSwitch
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  nocPkg::portVecT                       req,
  input  nocPkg::flitT [nocPkg::NumPorts-1:0]   portFlits,
  output nocPkg::portVecT                       grant,
  output nocPkg::flitT                          outFlit,
  output logic                                  outValid
);

  nocPkg::portVecT arbGrant;               // Feeds the crossbar and the port

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arbitration

  switchArbiter arbiter
  (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .portFlits (portFlits),
    .grant     (arbGrant)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data path, one cycle behind the grant

  flitCrossbar crossbar
  (
    .clk       (clk),
    .rst       (rst),
    .grant     (arbGrant),
    .req       (req),
    .portFlits (portFlits),
    .outFlit   (outFlit),
    .outValid  (outValid)
  );

  assign grant = arbGrant;

endmodule

// File: flitCrossbar.sv
`timescale 1ns/10ps

module flitCrossbar
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  nocPkg::portVecT                       grant,
  input  nocPkg::portVecT                       req,
  input  nocPkg::flitT [nocPkg::NumPorts-1:0]   portFlits,
  output nocPkg::flitT                          outFlit,
  output logic                                  outValid
);

  nocPkg::flitT selFlit;                   // Flit of the granted port
  logic         selValid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Five-to-one select on the one-hot grant

  always_comb
  begin
    selFlit = outFlit;                     // Hold when nothing is granted
    for (int i = 0; i < nocPkg::NumPorts; i++)
    begin
      if (grant[i])
        selFlit = portFlits[i];
    end
    selValid = |(grant & req);             // A dropped req gives no valid flit
  end

  // Output register
  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selValid;
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
  end

endmodule

// File: switchArbiter.sv
`timescale 1ns/10ps

module switchArbiter
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  nocPkg::portVecT                       req,
  input  nocPkg::flitT [nocPkg::NumPorts-1:0]   portFlits,
  output nocPkg::portVecT                       grant
);

  nocPkg::arbStateT state;
  nocPkg::arbStateT nextState;

  logic [nocPkg::NumPorts-1:0] runTimer;   // One run level per port timer
  logic [nocPkg::NumPorts-1:0] timesUp;

  nocPkg::portIdxT curPort;                // Port that holds the grant
  logic            active;                 // Low in idle
  nocPkg::portIdxT startPort;              // First port of the rotating scan
  nocPkg::portVecT otherReq;               // Requests without the current port

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers

  // State that grants port idx
  function automatic nocPkg::arbStateT portState(input nocPkg::portIdxT idx);
    portState = nocPkg::arbStateT'(6'b000010 << idx);
  endfunction

  // First requester scanning from start upward with wrap, idle if none
  function automatic nocPkg::arbStateT firstReq
  (
    input nocPkg::portVecT r,
    input nocPkg::portIdxT start
  );
    nocPkg::portIdxT idx;
    firstReq = nocPkg::ArbIdle;
    idx = start;
    for (int i = 0; i < nocPkg::NumPorts; i++)
    begin
      if (r[idx] && (firstReq == nocPkg::ArbIdle))
        firstReq = portState(idx);
      if (idx == 3'(nocPkg::NumPorts - 1))
        idx = 3'd0;
      else
        idx = idx + 3'd1;
    end
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Per-port timeout counters

  genvar k;
  generate
    for (k = 0; k < nocPkg::NumPorts; k++)
    begin : genTimer
      grantTimer portTimer
      (
        .clk      (clk),
        .rst      (rst),
        .portFlit (portFlits[k]),
        .run      (runTimer[k]),
        .timesUp  (timesUp[k])
      );
    end
  endgenerate

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State register

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocPkg::ArbIdle;
    else
      state <= nextState;
  end

  // Decode the one-hot state into a port number
  always_comb
  begin
    active  = 1'b1;
    curPort = 3'd0;
    case (state)
      nocPkg::ArbL: curPort = 3'd0;
      nocPkg::ArbN: curPort = 3'd1;
      nocPkg::ArbE: curPort = 3'd2;
      nocPkg::ArbW: curPort = 3'd3;
      nocPkg::ArbS: curPort = 3'd4;
      default:      active  = 1'b0;        // Idle or a broken encoding
    endcase
  end

  // Scan starts after the current port, which is masked out
  always_comb
  begin
    if (curPort == 3'(nocPkg::NumPorts - 1))
      startPort = 3'd0;
    else
      startPort = curPort + 3'd1;
    otherReq = req & ~nocPkg::portVecT'(5'b00001 << curPort);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state

  always_comb
  begin
    runTimer  = '0;
    nextState = nocPkg::ArbIdle;
    if (!active)
      nextState = firstReq(req, 3'd0);     // Fixed order L, N, E, W, S
    else if (req[curPort] && !timesUp[curPort])
    begin
      runTimer[curPort] = 1'b1;            // Keep the grant, count the cycle
      nextState         = state;
    end
    else
      nextState = firstReq(otherReq, startPort);
  end

  assign grant = nocPkg::portVecT'(state[nocPkg::NumPorts:1]);  // Idle bit dropped

endmodule

// File: grantTimer.sv
`timescale 1ns/10ps

module grantTimer
(
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::flitT portFlit,
  input  logic         run,
  output logic         timesUp
);

  nocPkg::pktLenT timeout;                 // Length of the last header seen
  nocPkg::pktLenT count;                   // Cycles spent in grant so far

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Length latch and cycle counter

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      timeout <= '0;
      count   <= '0;
    end
    else
    begin
      if (portFlit.id == nocPkg::HeaderId)
        timeout <= portFlit.len;           // Reload even when not granted
      if (run)
        count <= count + 12'd1;
      else
        count <= '0;                       // Any idle cycle restarts the count
    end
  end

  // Expiry in the same cycle as the match
  always_comb
  begin
    timesUp = (count == timeout);
  end

endmodule

// File: nocPkg.sv
package nocPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Router geometry

  localparam int NumPorts = 5;             // L, N, E, W, S

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flit format

  typedef logic [2:0]  flitIdT;            // Header, body or tail
  typedef logic [11:0] pktLenT;            // Timeout in clock cycles
  typedef logic [15:0] payloadT;

  localparam flitIdT HeaderId = 3'd1;      // Only this id reloads a timer

  typedef struct packed
  {
    flitIdT  id;
    pktLenT  len;
    payloadT payload;
  } flitT;                                 // 31 bits

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Port vectors and arbiter state

  typedef logic [NumPorts-1:0] portVecT;   // Bit 0 is L, then N, E, W, S
  typedef logic [2:0]          portIdxT;   // Port number 0 to 4

  // One-hot, the idle bit sits below the five port bits
  typedef enum logic [5:0]
  {
    ArbIdle = 6'b000001,
    ArbL    = 6'b000010,
    ArbN    = 6'b000100,
    ArbE    = 6'b001000,
    ArbW    = 6'b010000,
    ArbS    = 6'b100000
  } arbStateT;

endpackage
